// ==== src/systolic_pkg.sv ====
package systolic_pkg;

    ////////////////////
    // Array geometry
    ////////////////////

    // Edge length of the square PE grid
    localparam int MAT_MUL_SIZE      = 4;
    localparam int LOG2_MAT_MUL_SIZE = 2;

    ////////////////////
    // Data and address widths
    ////////////////////

    // Matrix elements are unsigned
    localparam int DWIDTH            = 8;
    // Wide enough for four full-scale products
    localparam int ACC_WIDTH         = 20;
    localparam int AWIDTH            = 6;
    localparam int MEM_DEPTH         = 1 << AWIDTH;
    localparam int ADDR_STRIDE_WIDTH = 4;
    localparam int MASK_WIDTH        = MAT_MUL_SIZE;
    localparam int CNT_WIDTH         = 8;

    ////////////////////
    // Latencies and counts
    ////////////////////

    // Cycles from read address to read data in matrix_bram
    localparam int MEM_ACCESS_LATENCY = 1;
    // Cycle count at which the last skewed product has been accumulated
    localparam int COMPUTE_CYCLES     = 3 * MAT_MUL_SIZE + MEM_ACCESS_LATENCY + 2;
    localparam int RESULT_COUNT       = MAT_MUL_SIZE * MAT_MUL_SIZE;
    localparam int RESULT_IDX_WIDTH   = 2 * LOG2_MAT_MUL_SIZE;

endpackage

// ==== src/matrix_bram.sv ====
`timescale 1ns/1ns

module matrix_bram
    import systolic_pkg::*;
(
    input  logic                             clk,

    // Load port, used while the subsystem is idle
    input  logic                             we,
    input  logic [AWIDTH-1:0]                waddr,
    input  logic [MAT_MUL_SIZE*DWIDTH-1:0]   wdata,

    // Read port with one cycle of latency
    input  logic [AWIDTH-1:0]                raddr,
    output logic [MAT_MUL_SIZE*DWIDTH-1:0]   rdata
);

    // Each word holds one column of A or one row of B
    logic [MAT_MUL_SIZE*DWIDTH-1:0] mem [MEM_DEPTH];

    always_ff @(posedge clk)
    begin
        if (we)
        begin
            mem[waddr] <= wdata;
        end
    end

    // Registered read gives MEM_ACCESS_LATENCY of one
    always_ff @(posedge clk)
    begin
        rdata <= mem[raddr];
    end

endmodule

// ==== src/matmul_control.sv ====
`timescale 1ns/1ns

module matmul_control
    import systolic_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n,

    input  logic                 start_valid,
    output logic                 start_ready,
    input  logic                 res_done,

    output logic                 busy,
    output logic [CNT_WIDTH-1:0] clk_cnt,
    output logic                 compute_done
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_COMPUTE,
        ST_DRAIN
    } state_t;

    state_t state;
    logic   start_xfer;
    logic   cnt_at_end;

    assign busy        = (state != ST_IDLE);
    assign start_ready = ~busy;
    assign start_xfer  = start_valid & start_ready;
    assign cnt_at_end  = (clk_cnt == CNT_WIDTH'(COMPUTE_CYCLES));

    // Single-cycle pulse that lets the drain load its first result
    assign compute_done = (state == ST_COMPUTE) & cnt_at_end;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state   <= ST_IDLE;
            clk_cnt <= '0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    if (start_xfer)
                    begin
                        state   <= ST_COMPUTE;
                        clk_cnt <= '0;
                    end
                end
                ST_COMPUTE:
                begin
                    if (cnt_at_end)
                        state <= ST_DRAIN;
                    else
                        clk_cnt <= clk_cnt + 1'b1;
                end
                // Drain length depends on res_ready back-pressure
                ST_DRAIN:
                begin
                    if (res_done)
                        state <= ST_IDLE;
                end
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

endmodule

// ==== src/systolic_data_setup.sv ====
`timescale 1ns/1ns

module systolic_data_setup
    import systolic_pkg::*;
(
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic                             busy,
    input  logic [CNT_WIDTH-1:0]             clk_cnt,

    input  logic [AWIDTH-1:0]                address_mat_a,
    input  logic [AWIDTH-1:0]                address_mat_b,
    input  logic [ADDR_STRIDE_WIDTH-1:0]     address_stride_a,
    input  logic [ADDR_STRIDE_WIDTH-1:0]     address_stride_b,
    input  logic [MAT_MUL_SIZE*DWIDTH-1:0]   a_data,
    input  logic [MAT_MUL_SIZE*DWIDTH-1:0]   b_data,

    input  logic [MASK_WIDTH-1:0]            validity_mask_a_rows,
    input  logic [MASK_WIDTH-1:0]            validity_mask_a_cols_b_rows,
    input  logic [MASK_WIDTH-1:0]            validity_mask_b_cols,

    output logic [AWIDTH-1:0]                a_addr,
    output logic [AWIDTH-1:0]                b_addr,
    output logic                             a_mem_access,
    output logic                             b_mem_access,
    output logic [MAT_MUL_SIZE*DWIDTH-1:0]   a_skewed,
    output logic [MAT_MUL_SIZE*DWIDTH-1:0]   b_skewed
);

    // Index 0 carries operand A and index 1 carries operand B
    logic [AWIDTH-1:0]                op_base      [2];
    logic [ADDR_STRIDE_WIDTH-1:0]     op_stride    [2];
    logic [MAT_MUL_SIZE*DWIDTH-1:0]   op_data      [2];
    logic [MASK_WIDTH-1:0]            op_lane_mask [2];
    logic [AWIDTH-1:0]                op_addr      [2];
    logic                             op_access    [2];
    logic [MAT_MUL_SIZE*DWIDTH-1:0]   op_skewed    [2];
    logic                             in_window;

    assign op_base[0]      = address_mat_a;
    assign op_base[1]      = address_mat_b;
    assign op_stride[0]    = address_stride_a;
    assign op_stride[1]    = address_stride_b;
    assign op_data[0]      = a_data;
    assign op_data[1]      = b_data;
    assign op_lane_mask[0] = validity_mask_a_rows;
    assign op_lane_mask[1] = validity_mask_b_cols;

    assign a_addr       = op_addr[0];
    assign b_addr       = op_addr[1];
    assign a_mem_access = op_access[0];
    assign b_mem_access = op_access[1];
    assign a_skewed     = op_skewed[0];
    assign b_skewed     = op_skewed[1];

    // One column of A and one row of B are read on counts 0 to 3
    assign in_window = (clk_cnt < CNT_WIDTH'(MAT_MUL_SIZE));

    for (genvar op = 0; op < 2; op++)
    begin : g_op
        logic [LOG2_MAT_MUL_SIZE:0] access_cnt;
        logic [LOG2_MAT_MUL_SIZE:0] k_idx;
        logic                       data_valid;

        ////////////////////
        // Address generation
        ////////////////////

        // Idle value sits one stride below the base so the first step lands on it
        always_ff @(posedge clk or negedge arst_n)
        begin
            if (!arst_n)
            begin
                op_addr[op]   <= '0;
                op_access[op] <= 1'b0;
            end
            else if (!busy || !in_window)
            begin
                op_addr[op]   <= op_base[op] - AWIDTH'(op_stride[op]);
                op_access[op] <= 1'b0;
            end
            else
            begin
                op_addr[op]   <= op_addr[op] + AWIDTH'(op_stride[op]);
                op_access[op] <= 1'b1;
            end
        end

        ////////////////////
        // Read validity
        ////////////////////

        always_ff @(posedge clk or negedge arst_n)
        begin
            if (!arst_n)
                access_cnt <= '0;
            else if (busy && op_access[op])
                access_cnt <= access_cnt + 1'b1;
            else
                access_cnt <= '0;
        end

        // Count k plus the read latency marks the word for shared index k
        assign k_idx      = access_cnt - (LOG2_MAT_MUL_SIZE+1)'(MEM_ACCESS_LATENCY);
        assign data_valid = (access_cnt >= (LOG2_MAT_MUL_SIZE+1)'(MEM_ACCESS_LATENCY)) &&
                            (k_idx < (LOG2_MAT_MUL_SIZE+1)'(MAT_MUL_SIZE)) &&
                            validity_mask_a_cols_b_rows[k_idx[LOG2_MAT_MUL_SIZE-1:0]];

        ////////////////////
        // Lane gating and skew
        ////////////////////

        for (genvar lane = 0; lane < MAT_MUL_SIZE; lane++)
        begin : g_lane
            logic [DWIDTH-1:0] gated;

            assign gated = op_data[op][lane*DWIDTH +: DWIDTH] &
                           {DWIDTH{data_valid & op_lane_mask[op][lane]}};

            if (lane == 0)
            begin : g_direct
                assign op_skewed[op][DWIDTH-1:0] = gated;
            end
            else
            begin : g_delay
                // Lane i waits i cycles so it meets its partner at the right PE
                logic [DWIDTH-1:0] chain [lane];

                always_ff @(posedge clk or negedge arst_n)
                begin
                    if (!arst_n)
                        chain <= '{default: '0};
                    else if (!busy)
                        chain <= '{default: '0};
                    else
                    begin
                        chain[0] <= gated;
                        for (int s = 1; s < lane; s++)
                            chain[s] <= chain[s-1];
                    end
                end

                assign op_skewed[op][lane*DWIDTH +: DWIDTH] = chain[lane-1];
            end
        end
    end

endmodule

// ==== src/processing_element.sv ====
`timescale 1ns/1ns

module processing_element
    import systolic_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 clear,

    input  logic [DWIDTH-1:0]    a_in,
    input  logic [DWIDTH-1:0]    b_in,
    output logic [DWIDTH-1:0]    a_out,
    output logic [DWIDTH-1:0]    b_out,
    output logic [ACC_WIDTH-1:0] acc
);

    logic [2*DWIDTH-1:0] product;

    assign product = a_in * b_in;

    // A moves right and B moves down, one cycle per PE
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            a_out <= '0;
            b_out <= '0;
            acc   <= '0;
        end
        else if (clear)
        begin
            a_out <= '0;
            b_out <= '0;
            acc   <= '0;
        end
        else
        begin
            a_out <= a_in;
            b_out <= b_in;
            acc   <= acc + ACC_WIDTH'(product);
        end
    end

endmodule

// ==== src/systolic_array.sv ====
`timescale 1ns/1ns

module systolic_array
    import systolic_pkg::*;
(
    input  logic                                      clk,
    input  logic                                      arst_n,
    input  logic                                      clear,

    input  logic [MAT_MUL_SIZE*DWIDTH-1:0]            a_skewed,
    input  logic [MAT_MUL_SIZE*DWIDTH-1:0]            b_skewed,

    // Element (i,j) sits at index i*MAT_MUL_SIZE+j
    output logic [RESULT_COUNT*ACC_WIDTH-1:0]         acc_flat
);

    // Horizontal A links, column index MAT_MUL_SIZE is the right edge
    logic [DWIDTH-1:0] a_link [MAT_MUL_SIZE][MAT_MUL_SIZE+1];
    // Vertical B links, row index MAT_MUL_SIZE is the bottom edge
    logic [DWIDTH-1:0] b_link [MAT_MUL_SIZE+1][MAT_MUL_SIZE];

    for (genvar n = 0; n < MAT_MUL_SIZE; n++)
    begin : g_edge
        assign a_link[n][0] = a_skewed[n*DWIDTH +: DWIDTH];
        assign b_link[0][n] = b_skewed[n*DWIDTH +: DWIDTH];
    end

    for (genvar i = 0; i < MAT_MUL_SIZE; i++)
    begin : g_row
        for (genvar j = 0; j < MAT_MUL_SIZE; j++)
        begin : g_col
            processing_element i_pe (
                .clk    (clk),
                .arst_n (arst_n),
                .clear  (clear),
                .a_in   (a_link[i][j]),
                .b_in   (b_link[i][j]),
                .a_out  (a_link[i][j+1]),
                .b_out  (b_link[i+1][j]),
                .acc    (acc_flat[(i*MAT_MUL_SIZE+j)*ACC_WIDTH +: ACC_WIDTH])
            );
        end
    end

endmodule

// ==== src/result_drain.sv ====
`timescale 1ns/1ns

module result_drain
    import systolic_pkg::*;
(
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  logic                                 compute_done,
    input  logic [RESULT_COUNT*ACC_WIDTH-1:0]    acc_flat,

    output logic                                 res_valid,
    output logic [ACC_WIDTH-1:0]                 res_data,
    output logic                                 res_last,
    input  logic                                 res_ready,
    output logic                                 res_done
);

    logic [RESULT_IDX_WIDTH-1:0] idx;
    logic [RESULT_IDX_WIDTH-1:0] next_idx;
    logic                        xfer;

    assign xfer     = res_valid & res_ready;
    assign next_idx = idx + 1'b1;
    assign res_done = xfer & res_last;

    ////////////////////
    // Handshake state
    ////////////////////

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            res_valid <= 1'b0;
            res_last  <= 1'b0;
            idx       <= '0;
        end
        else if (compute_done)
        begin
            res_valid <= 1'b1;
            res_last  <= 1'b0;
            idx       <= '0;
        end
        else if (xfer)
        begin
            if (res_last)
            begin
                res_valid <= 1'b0;
                res_last  <= 1'b0;
            end
            else
            begin
                idx      <= next_idx;
                res_last <= (next_idx == RESULT_IDX_WIDTH'(RESULT_COUNT-1));
            end
        end
    end

    ////////////////////
    // Result data
    ////////////////////

    // Held while res_ready is low, advanced row-major on each accepted result
    always_ff @(posedge clk)
    begin
        if (compute_done)
            res_data <= acc_flat[0 +: ACC_WIDTH];
        else if (xfer && !res_last)
            res_data <= acc_flat[next_idx*ACC_WIDTH +: ACC_WIDTH];
    end

endmodule

// ==== src/systolic_matmul_top.sv ====
`timescale 1ns/1ns

module systolic_matmul_top
    import systolic_pkg::*;
(
    input  logic                             clk,
    input  logic                             arst_n,

    // Memory load, mem_sel picks A (0) or B (1)
    input  logic                             mem_we,
    input  logic                             mem_sel,
    input  logic [AWIDTH-1:0]                mem_waddr,
    input  logic [MAT_MUL_SIZE*DWIDTH-1:0]   mem_wdata,

    // Command
    input  logic                             start_valid,
    output logic                             start_ready,
    input  logic [AWIDTH-1:0]                address_mat_a,
    input  logic [AWIDTH-1:0]                address_mat_b,
    input  logic [ADDR_STRIDE_WIDTH-1:0]     address_stride_a,
    input  logic [ADDR_STRIDE_WIDTH-1:0]     address_stride_b,
    input  logic [MASK_WIDTH-1:0]            validity_mask_a_rows,
    input  logic [MASK_WIDTH-1:0]            validity_mask_a_cols_b_rows,
    input  logic [MASK_WIDTH-1:0]            validity_mask_b_cols,

    // Result stream
    output logic                             res_valid,
    output logic [ACC_WIDTH-1:0]             res_data,
    output logic                             res_last,
    input  logic                             res_ready
);

    logic                                 busy;
    logic [CNT_WIDTH-1:0]                 clk_cnt;
    logic                                 compute_done;
    logic                                 res_done;
    logic                                 start_xfer;
    logic [AWIDTH-1:0]                    a_addr;
    logic [AWIDTH-1:0]                    b_addr;
    logic [MAT_MUL_SIZE*DWIDTH-1:0]       a_data;
    logic [MAT_MUL_SIZE*DWIDTH-1:0]       b_data;
    logic [MAT_MUL_SIZE*DWIDTH-1:0]       a_skewed;
    logic [MAT_MUL_SIZE*DWIDTH-1:0]       b_skewed;
    logic [RESULT_COUNT*ACC_WIDTH-1:0]    acc_flat;

    // Accumulators clear on the same edge that accepts a command
    assign start_xfer = start_valid & start_ready;

    matrix_bram i_bram_a (
        .clk   (clk),
        .we    (mem_we & ~mem_sel),
        .waddr (mem_waddr),
        .wdata (mem_wdata),
        .raddr (a_addr),
        .rdata (a_data)
    );

    matrix_bram i_bram_b (
        .clk   (clk),
        .we    (mem_we & mem_sel),
        .waddr (mem_waddr),
        .wdata (mem_wdata),
        .raddr (b_addr),
        .rdata (b_data)
    );

    matmul_control i_control (
        .clk          (clk),
        .arst_n       (arst_n),
        .start_valid  (start_valid),
        .start_ready  (start_ready),
        .res_done     (res_done),
        .busy         (busy),
        .clk_cnt      (clk_cnt),
        .compute_done (compute_done)
    );

    // The access flags only pace the setup block internally
    systolic_data_setup i_data_setup (
        .clk                         (clk),
        .arst_n                      (arst_n),
        .busy                        (busy),
        .clk_cnt                     (clk_cnt),
        .address_mat_a               (address_mat_a),
        .address_mat_b               (address_mat_b),
        .address_stride_a            (address_stride_a),
        .address_stride_b            (address_stride_b),
        .a_data                      (a_data),
        .b_data                      (b_data),
        .validity_mask_a_rows        (validity_mask_a_rows),
        .validity_mask_a_cols_b_rows (validity_mask_a_cols_b_rows),
        .validity_mask_b_cols        (validity_mask_b_cols),
        .a_addr                      (a_addr),
        .b_addr                      (b_addr),
        .a_mem_access                (),
        .b_mem_access                (),
        .a_skewed                    (a_skewed),
        .b_skewed                    (b_skewed)
    );

    systolic_array i_array (
        .clk      (clk),
        .arst_n   (arst_n),
        .clear    (start_xfer),
        .a_skewed (a_skewed),
        .b_skewed (b_skewed),
        .acc_flat (acc_flat)
    );

    result_drain i_drain (
        .clk          (clk),
        .arst_n       (arst_n),
        .compute_done (compute_done),
        .acc_flat     (acc_flat),
        .res_valid    (res_valid),
        .res_data     (res_data),
        .res_last     (res_last),
        .res_ready    (res_ready),
        .res_done     (res_done)
    );

endmodule

// ==== testbench/tb_systolic_matmul.sv ====
`timescale 1ns/1ns

module tb_systolic_matmul
    import systolic_pkg::*;
();

    localparam int CLK_PERIOD    = 8;
    localparam int RESET_CYCLES  = 8;
    localparam int COMMAND_COUNT = 6;
    // Load, compute and a generous drain allowance for one command
    localparam int CMD_CYCLES    = 2 * MAT_MUL_SIZE + COMPUTE_CYCLES + 4 + 4 * RESULT_COUNT;
    localparam int WATCHDOG_NS   = 2 * (RESET_CYCLES + COMMAND_COUNT * CMD_CYCLES) * CLK_PERIOD;

    logic                           clk;
    logic                           arst_n;
    logic                           mem_we;
    logic                           mem_sel;
    logic [AWIDTH-1:0]              mem_waddr;
    logic [MAT_MUL_SIZE*DWIDTH-1:0] mem_wdata;
    logic                           start_valid;
    logic                           start_ready;
    logic [AWIDTH-1:0]              address_mat_a;
    logic [AWIDTH-1:0]              address_mat_b;
    logic [ADDR_STRIDE_WIDTH-1:0]   address_stride_a;
    logic [ADDR_STRIDE_WIDTH-1:0]   address_stride_b;
    logic [MASK_WIDTH-1:0]          validity_mask_a_rows;
    logic [MASK_WIDTH-1:0]          validity_mask_a_cols_b_rows;
    logic [MASK_WIDTH-1:0]          validity_mask_b_cols;
    logic                           res_valid;
    logic [ACC_WIDTH-1:0]           res_data;
    logic                           res_last;
    logic                           res_ready;

    logic [DWIDTH-1:0]    mat_a [MAT_MUL_SIZE][MAT_MUL_SIZE];
    logic [DWIDTH-1:0]    mat_b [MAT_MUL_SIZE][MAT_MUL_SIZE];
    logic [ACC_WIDTH-1:0] expect_q [$];
    logic [31:0]          rng_state;

    systolic_matmul_top i_dut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////
    // Helpers
    ////////////////////

    function automatic logic [15:0] next_random();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state[31:16];
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("ERROR at %0t ns: %s expected 0x%0h, actual 0x%0h",
                     $time, name, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic fill_random();
        for (int i = 0; i < MAT_MUL_SIZE; i++)
            for (int j = 0; j < MAT_MUL_SIZE; j++)
            begin
                mat_a[i][j] = DWIDTH'(next_random());
                mat_b[i][j] = DWIDTH'(next_random());
            end
    endtask

    // Column k of A and row k of B each go to one word at base plus k times stride
    task automatic load_matrices(input logic [AWIDTH-1:0] base_a,
                                 input logic [ADDR_STRIDE_WIDTH-1:0] stride_a,
                                 input logic [AWIDTH-1:0] base_b,
                                 input logic [ADDR_STRIDE_WIDTH-1:0] stride_b);
        for (int k = 0; k < MAT_MUL_SIZE; k++)
        begin
            @(posedge clk);
            #1;
            mem_we    = 1'b1;
            mem_sel   = 1'b0;
            mem_waddr = base_a + AWIDTH'(k * stride_a);
            for (int i = 0; i < MAT_MUL_SIZE; i++)
                mem_wdata[i*DWIDTH +: DWIDTH] = mat_a[i][k];
            @(posedge clk);
            #1;
            mem_sel   = 1'b1;
            mem_waddr = base_b + AWIDTH'(k * stride_b);
            for (int j = 0; j < MAT_MUL_SIZE; j++)
                mem_wdata[j*DWIDTH +: DWIDTH] = mat_b[k][j];
        end
        @(posedge clk);
        #1;
        mem_we = 1'b0;
    endtask

    // Masked product, pushed in row-major order
    task automatic compute_reference(input logic [MASK_WIDTH-1:0] mask_a,
                                     input logic [MASK_WIDTH-1:0] mask_k,
                                     input logic [MASK_WIDTH-1:0] mask_b);
        int sum;
        for (int i = 0; i < MAT_MUL_SIZE; i++)
            for (int j = 0; j < MAT_MUL_SIZE; j++)
            begin
                sum = 0;
                for (int k = 0; k < MAT_MUL_SIZE; k++)
                    if (mask_a[i] && mask_k[k] && mask_b[j])
                        sum += int'(mat_a[i][k]) * int'(mat_b[k][j]);
                expect_q.push_back(ACC_WIDTH'(sum));
            end
    endtask

    // Issues one command and collects its 16 results against expect_q
    task automatic run_command(input logic [AWIDTH-1:0] base_a, input logic [AWIDTH-1:0] base_b,
                               input logic [ADDR_STRIDE_WIDTH-1:0] stride_a,
                               input logic [ADDR_STRIDE_WIDTH-1:0] stride_b,
                               input logic [MASK_WIDTH-1:0] mask_a,
                               input logic [MASK_WIDTH-1:0] mask_k,
                               input logic [MASK_WIDTH-1:0] mask_b, input bit random_ready);
        int                   got;
        bit                   held;
        logic [ACC_WIDTH-1:0] held_data;
        logic                 held_last;
        logic [15:0]          rnd;
        @(posedge clk);
        #1;
        address_mat_a               = base_a;
        address_mat_b               = base_b;
        address_stride_a            = stride_a;
        address_stride_b            = stride_b;
        validity_mask_a_rows        = mask_a;
        validity_mask_a_cols_b_rows = mask_k;
        validity_mask_b_cols        = mask_b;
        start_valid                 = 1'b1;
        @(negedge clk);
        check_value("start_ready", 1, start_ready);
        @(posedge clk);
        #1;
        start_valid = 1'b0;
        got         = 0;
        held        = 1'b0;
        while (got < RESULT_COUNT)
        begin
            rnd       = next_random();
            res_ready = random_ready ? (rnd[1:0] != 2'b00) : 1'b1;
            @(negedge clk);
            check_value("start_ready", 0, start_ready);
            // A stalled result must stay put until it is taken
            if (held)
            begin
                check_value("res_valid", 1, res_valid);
                check_value("res_data", held_data, res_data);
                check_value("res_last", held_last, res_last);
            end
            held      = res_valid && !res_ready;
            held_data = res_data;
            held_last = res_last;
            if (res_valid && res_ready)
            begin
                check_value("res_data", expect_q.pop_front(), res_data);
                check_value("res_last", (got == RESULT_COUNT - 1), res_last);
                got++;
            end
            @(posedge clk);
            #1;
        end
        res_ready = 1'b0;
        check_value("start_ready", 1, start_ready);
        check_value("res_valid", 0, res_valid);
    endtask

    ////////////////////
    // Tests
    ////////////////////

    task automatic test_reset_state();
        @(negedge clk);
        check_value("start_ready", 1, start_ready);
        check_value("res_valid", 0, res_valid);
        check_value("res_last", 0, res_last);
    endtask

    task automatic test_identity();
        fill_random();
        for (int i = 0; i < MAT_MUL_SIZE; i++)
            for (int j = 0; j < MAT_MUL_SIZE; j++)
            begin
                mat_a[i][j] = (i == j) ? 8'd1 : 8'd0;
                expect_q.push_back(ACC_WIDTH'(mat_b[i][j]));
            end
        load_matrices(0, 1, 0, 1);
        run_command(0, 0, 1, 1, 4'b1111, 4'b1111, 4'b1111, 1'b0);
    endtask

    task automatic test_strided();
        fill_random();
        load_matrices(5, 2, 20, 3);
        compute_reference(4'b1111, 4'b1111, 4'b1111);
        run_command(5, 20, 2, 3, 4'b1111, 4'b1111, 4'b1111, 1'b0);
    endtask

    task automatic test_masked();
        fill_random();
        load_matrices(40, 1, 50, 4);
        compute_reference(4'b1011, 4'b1101, 4'b0111);
        run_command(40, 50, 1, 4, 4'b1011, 4'b1101, 4'b0111, 1'b0);
    endtask

    task automatic test_backpressure();
        fill_random();
        load_matrices(8, 3, 30, 2);
        compute_reference(4'b1111, 4'b1111, 4'b1111);
        run_command(8, 30, 3, 2, 4'b1111, 4'b1111, 4'b1111, 1'b1);
    endtask

    // Both operand sets are loaded first so the two commands run with no load between
    task automatic test_back_to_back();
        fill_random();
        load_matrices(0, 1, 16, 1);
        compute_reference(4'b1111, 4'b1111, 4'b1111);
        fill_random();
        load_matrices(32, 2, 48, 3);
        compute_reference(4'b1110, 4'b0111, 4'b1101);
        run_command(0, 16, 1, 1, 4'b1111, 4'b1111, 4'b1111, 1'b0);
        run_command(32, 48, 2, 3, 4'b1110, 4'b0111, 4'b1101, 1'b1);
    endtask

    ////////////////////
    // Main sequence and watchdog
    ////////////////////

    initial
    begin
        rng_state                   = 32'd35;
        clk                         = 1'b0;
        arst_n                      = 1'b0;
        mem_we                      = 1'b0;
        mem_sel                     = 1'b0;
        mem_waddr                   = '0;
        mem_wdata                   = '0;
        start_valid                 = 1'b0;
        address_mat_a               = '0;
        address_mat_b               = '0;
        address_stride_a            = '0;
        address_stride_b            = '0;
        validity_mask_a_rows        = '0;
        validity_mask_a_cols_b_rows = '0;
        validity_mask_b_cols        = '0;
        res_ready                   = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        arst_n = 1'b1;
        test_reset_state();
        test_identity();
        test_strided();
        test_masked();
        test_backpressure();
        test_back_to_back();
        $display("SIMULATION PASSED");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("SIMULATION FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== compile.f ====
src/systolic_pkg.sv
src/matrix_bram.sv
src/matmul_control.sv
src/systolic_data_setup.sv
src/processing_element.sv
src/systolic_array.sv
src/result_drain.sv
src/systolic_matmul_top.sv
testbench/tb_systolic_matmul.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it; the exit status is the result
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f compile.f \
    --top-module tb_systolic_matmul -Mdir obj_dir -o tb_sim &&
./obj_dir/tb_sim ||
{ echo "Build or simulation did not complete successfully"; exit 1; }
